/* alu_settings.svh */
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// datapath width
`define ALU_WIDTH 32

// operation code width
`define ALU_OP_BITS 5

// shift count field in op2
`define ALU_COUNT_BITS 5

// AND masking mode keeps the low half-word
`define ALU_AND_INT_MASK 32'h0000_FFFF

// forced shift count
`define ALU_FIXED_SHIFT 2

`endif

/* alu_pkg.sv */
`default_nettype none

`include "alu_settings.svh"

package alu_pkg;

    // one datapath word
    typedef logic [`ALU_WIDTH-1:0] alu_word_t;

    // operation codes, gaps are unused codes
    typedef enum logic [`ALU_OP_BITS-1:0] {
        op_and     = 5'd0,
        op_add     = 5'd1,
        op_bsf     = 5'd2,
        op_movb    = 5'd3,
        op_mova    = 5'd4,
        op_cld     = 5'd5,
        op_std     = 5'd6,
        op_cmpxchg = 5'd7,
        op_daa     = 5'd8,
        op_not     = 5'd9,
        op_or      = 5'd10,
        op_sar     = 5'd17,
        op_sal     = 5'd18,
        op_cmovc   = 5'd19
    } alu_op_t;

    // operand size, code 3 acts as dword
    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_word  = 2'd1,
        size_dword = 2'd2
    } alu_size_t;

endpackage

`default_nettype wire

/* alu_logic_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "alu_settings.svh"

module alu_logic_unit
    import alu_pkg::*;
(
    input  alu_op_t   aluk,
    input  alu_word_t op1,
    input  alu_word_t op2,
    input  wire logic and_int,
    input  wire logic cf_in,
    output alu_word_t logic_result,
    output logic      bsf_zero
);

    localparam int IDX_BITS = $clog2(`ALU_WIDTH);

    alu_word_t           and_operand;
    logic [IDX_BITS-1:0] bsf_index;

    // masking mode replaces op2 with the low half-word mask
    assign and_operand = and_int ? alu_word_t'(`ALU_AND_INT_MASK) : op2;

    ////////////////////////////////////////
    // bit scan forward
    ////////////////////////////////////////

    // walk down from the top so the lowest set bit wins
    always_comb begin
        bsf_index = '0;
        for (int i = `ALU_WIDTH - 1; i >= 0; i--) begin
            if (op1[i]) begin
                bsf_index = IDX_BITS'(i);
            end
        end
    end

    assign bsf_zero = (op1 == '0);

    always_comb begin
        case (aluk)
            op_and:   logic_result = op1 & and_operand;
            op_or:    logic_result = op1 | op2;
            op_not:   logic_result = ~op1;
            op_mova:  logic_result = op1;
            op_movb:  logic_result = op2;
            // move only when carry is set
            op_cmovc: logic_result = cf_in ? op2 : op1;
            op_cld:   logic_result = '0;
            op_std:   logic_result = alu_word_t'(1);
            op_bsf:   logic_result = alu_word_t'(bsf_index);
            default:  logic_result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* alu_arith.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_arith
    import alu_pkg::*;
(
    input  alu_op_t   aluk,
    input  alu_size_t size,
    input  alu_word_t op1,
    input  alu_word_t op2,
    input  alu_word_t op3,
    output alu_word_t arith_result,
    output logic      arith_cf,
    output logic      arith_af,
    output logic      arith_of,
    output logic      swap,
    output logic      cmp_equal
);

    localparam int W = $bits(alu_word_t);

    alu_word_t add_sum;
    logic      add_carry;
    logic      add_af;
    logic      add_of;
    int        top_bit;
    alu_word_t sub_diff;
    logic      sub_borrow;
    logic      sub_af;
    logic      sub_of;

    ////////////////////////////////////////
    // add
    ////////////////////////////////////////

    assign {add_carry, add_sum} = {1'b0, op1} + {1'b0, op2};

    // carry into bit 4 is the nibble carry
    assign add_af = add_sum[4] ^ op1[4] ^ op2[4];

    // sign bit of the operand size
    always_comb begin
        case (size)
            size_byte: top_bit = 7;
            size_word: top_bit = 15;
            default:   top_bit = W - 1;
        endcase
    end

    assign add_of = (op1[top_bit] == op2[top_bit]) && (add_sum[top_bit] != op1[top_bit]);

    ////////////////////////////////////////
    // cmpxchg compare
    ////////////////////////////////////////

    // flags of op1 - op2, always at full width
    assign {sub_borrow, sub_diff} = {1'b0, op1} - {1'b0, op2};
    assign sub_af = sub_diff[4] ^ op1[4] ^ op2[4];
    assign sub_of = (op1[W-1] != op2[W-1]) && (sub_diff[W-1] != op1[W-1]);

    assign cmp_equal = (op1 == op3);
    assign swap      = (aluk == op_cmpxchg) && cmp_equal;

    always_comb begin
        if (aluk == op_cmpxchg) begin
            arith_result = cmp_equal ? op2 : op1;
            arith_cf     = sub_borrow;
            arith_af     = sub_af;
            arith_of     = sub_of;
        end else begin
            arith_result = add_sum;
            arith_cf     = add_carry;
            arith_af     = add_af;
            arith_of     = add_of;
        end
    end

endmodule

`default_nettype wire

/* alu_bcd_adjust.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_bcd_adjust
    import alu_pkg::*;
(
    input  alu_word_t op1,
    input  wire logic af_in,
    input  wire logic cf_in,
    output alu_word_t daa_result,
    output logic      daa_af,
    output logic      daa_cf
);

    logic [7:0] al;
    logic [7:0] al_low_fixed;
    logic [7:0] al_fixed;
    logic       low_adjust;
    logic       high_adjust;

    assign al = op1[7:0];

    // low digit out of range or nibble carry seen
    assign low_adjust   = (al[3:0] > 4'd9) || af_in;
    assign al_low_fixed = low_adjust ? al + 8'h06 : al;

    // high digit check looks at the AL before any adjust
    assign high_adjust = (al > 8'h99) || cf_in;
    assign al_fixed    = high_adjust ? al_low_fixed + 8'h60 : al_low_fixed;

    assign daa_result = alu_word_t'(al_fixed);
    assign daa_af     = low_adjust;
    assign daa_cf     = high_adjust;

endmodule

`default_nettype wire

/* alu_shifter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "alu_settings.svh"

module alu_shifter
    import alu_pkg::*;
(
    input  alu_op_t   aluk,
    input  alu_word_t op1,
    input  alu_word_t op2,
    input  wire logic fixed_shift,
    input  wire logic of_in,
    output alu_word_t shift_result,
    output logic      shift_cf,
    output logic      shift_of,
    output logic      count_zero
);

    localparam int W        = `ALU_WIDTH;
    localparam int CNT_BITS = `ALU_COUNT_BITS;

    logic [CNT_BITS-1:0] count;
    logic                overshift;
    logic [W:0]          sal_wide;
    logic [W:0]          sar_wide;
    alu_word_t           sal_result;
    alu_word_t           sar_result;
    logic                sal_cf;
    logic                sar_cf;

    ////////////////////////////////////////
    // count and overshift
    ////////////////////////////////////////

    assign count = fixed_shift ? CNT_BITS'(`ALU_FIXED_SHIFT) : op2[CNT_BITS-1:0];

    // count bits above the field, ignored in forced mode
    assign overshift = (|op2[7:CNT_BITS]) && !fixed_shift;

    ////////////////////////////////////////
    // shift paths
    ////////////////////////////////////////

    // extra bit on the out side catches the last bit shifted out
    assign sal_wide = {1'b0, op1} << count;
    assign sar_wide = $signed({op1, 1'b0}) >>> count;

    always_comb begin
        if (overshift) begin
            sal_result = '0;
            sal_cf     = 1'b0;
        end else begin
            sal_result = sal_wide[W-1:0];
            sal_cf     = sal_wide[W];
        end
    end

    always_comb begin
        if (overshift) begin
            // everything shifted out, only sign copies remain
            sar_result = {W{op1[W-1]}};
            sar_cf     = op1[W-1];
        end else begin
            sar_result = sar_wide[W:1];
            sar_cf     = sar_wide[0];
        end
    end

    ////////////////////////////////////////
    // result and flags
    ////////////////////////////////////////

    always_comb begin
        if (aluk == op_sal) begin
            shift_result = sal_result;
            shift_cf     = sal_cf;
        end else begin
            shift_result = sar_result;
            shift_cf     = sar_cf;
        end
    end

    // OF is only defined for single-bit shifts
    always_comb begin
        if (count == CNT_BITS'(1)) begin
            shift_of = (aluk == op_sal) ? (shift_result[W-1] ^ shift_cf) : 1'b0;
        end else begin
            shift_of = of_in;
        end
    end

    // flags keep their old value on a zero count
    assign count_zero = (count == '0) && !overshift;

endmodule

`default_nettype wire

/* alu_result_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_result_stage
    import alu_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  alu_op_t   aluk,
    input  alu_size_t size,
    input  alu_word_t logic_result,
    input  alu_word_t arith_result,
    input  wire logic arith_cf,
    input  wire logic arith_af,
    input  wire logic arith_of,
    input  alu_word_t daa_result,
    input  wire logic daa_af,
    input  wire logic daa_cf,
    input  alu_word_t shift_result,
    input  wire logic shift_cf,
    input  wire logic shift_of,
    input  wire logic bsf_zero,
    input  wire logic cmp_equal,
    input  wire logic swap_req,
    input  wire logic count_zero,
    output alu_word_t alu_out,
    output logic      swap,
    output logic      cf_out,
    output logic      pf_out,
    output logic      af_out,
    output logic      zf_out,
    output logic      sf_out,
    output logic      of_out,
    output logic      df_out,
    output logic      cc_inval
);

    alu_word_t sel_result;
    alu_word_t size_masked;
    logic      sel_cf;
    logic      sel_af;
    logic      sel_of;
    logic      op_known;
    logic      sel_zf;
    logic      sel_sf;
    logic      sel_pf;
    logic      is_shift;

    ////////////////////////////////////////
    // per-operation select
    ////////////////////////////////////////

    always_comb begin
        sel_result = '0;
        sel_cf     = 1'b0;
        sel_af     = 1'b0;
        sel_of     = 1'b0;
        op_known   = 1'b1;
        case (aluk)
            op_and, op_or, op_not, op_mova, op_movb, op_cmovc, op_cld, op_std, op_bsf: begin
                sel_result = logic_result;
            end
            op_add, op_cmpxchg: begin
                sel_result = arith_result;
                sel_cf     = arith_cf;
                sel_af     = arith_af;
                sel_of     = arith_of;
            end
            op_daa: begin
                sel_result = daa_result;
                sel_cf     = daa_cf;
                sel_af     = daa_af;
            end
            op_sal, op_sar: begin
                sel_result = shift_result;
                sel_cf     = shift_cf;
                sel_of     = shift_of;
            end
            default: op_known = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // zero, sign, parity
    ////////////////////////////////////////

    always_comb begin
        case (size)
            size_byte: begin
                size_masked = sel_result & alu_word_t'(8'hFF);
                sel_sf      = sel_result[7];
            end
            size_word: begin
                size_masked = sel_result & alu_word_t'(16'hFFFF);
                sel_sf      = sel_result[15];
            end
            default: begin
                size_masked = sel_result;
                sel_sf      = sel_result[$bits(alu_word_t)-1];
            end
        endcase
    end

    always_comb begin
        case (aluk)
            op_bsf:     sel_zf = bsf_zero;
            op_cmpxchg: sel_zf = cmp_equal;
            default:    sel_zf = (size_masked == '0);
        endcase
    end

    // even parity of the low byte
    assign sel_pf   = ~^sel_result[7:0];
    assign is_shift = (aluk == op_sal) || (aluk == op_sar);

    ////////////////////////////////////////
    // output registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_out  <= '0;
            swap     <= 1'b0;
            cf_out   <= 1'b0;
            pf_out   <= 1'b0;
            af_out   <= 1'b0;
            zf_out   <= 1'b0;
            sf_out   <= 1'b0;
            of_out   <= 1'b0;
            df_out   <= 1'b0;
            cc_inval <= 1'b0;
        end else begin
            alu_out  <= sel_result;
            swap     <= swap_req;
            cf_out   <= sel_cf;
            af_out   <= sel_af;
            of_out   <= sel_of;
            // unused codes report no flags at all
            pf_out   <= sel_pf && op_known;
            zf_out   <= sel_zf && op_known;
            sf_out   <= sel_sf && op_known;
            df_out   <= (aluk == op_std);
            cc_inval <= is_shift && count_zero;
        end
    end

endmodule

`default_nettype wire

/* alu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_top
    import alu_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  alu_op_t        aluk,
    input  alu_size_t      size,
    input  alu_word_t      op1,
    input  alu_word_t      op2,
    input  alu_word_t      op3,
    input  wire logic      and_int,
    input  wire logic      fixed_shift,
    input  wire logic      af_in,
    input  wire logic      cf_in,
    input  wire logic      of_in,
    output alu_word_t      alu_out,
    output logic           swap,
    output logic           cf_out,
    output logic           pf_out,
    output logic           af_out,
    output logic           zf_out,
    output logic           sf_out,
    output logic           of_out,
    output logic           df_out,
    output logic           cc_inval
);

    alu_word_t logic_result;
    alu_word_t arith_result;
    alu_word_t daa_result;
    alu_word_t shift_result;
    logic      bsf_zero;
    logic      arith_cf;
    logic      arith_af;
    logic      arith_of;
    logic      arith_swap;
    logic      cmp_equal;
    logic      daa_af;
    logic      daa_cf;
    logic      shift_cf;
    logic      shift_of;
    logic      count_zero;

    ////////////////////////////////////////
    // operation units
    ////////////////////////////////////////

    alu_logic_unit u_logic (
        .aluk         (aluk),
        .op1          (op1),
        .op2          (op2),
        .and_int      (and_int),
        .cf_in        (cf_in),
        .logic_result (logic_result),
        .bsf_zero     (bsf_zero)
    );

    alu_arith u_arith (
        .aluk         (aluk),
        .size         (size),
        .op1          (op1),
        .op2          (op2),
        .op3          (op3),
        .arith_result (arith_result),
        .arith_cf     (arith_cf),
        .arith_af     (arith_af),
        .arith_of     (arith_of),
        .swap         (arith_swap),
        .cmp_equal    (cmp_equal)
    );

    alu_bcd_adjust u_daa (
        .op1        (op1),
        .af_in      (af_in),
        .cf_in      (cf_in),
        .daa_result (daa_result),
        .daa_af     (daa_af),
        .daa_cf     (daa_cf)
    );

    alu_shifter u_shift (
        .aluk         (aluk),
        .op1          (op1),
        .op2          (op2),
        .fixed_shift  (fixed_shift),
        .of_in        (of_in),
        .shift_result (shift_result),
        .shift_cf     (shift_cf),
        .shift_of     (shift_of),
        .count_zero   (count_zero)
    );

    ////////////////////////////////////////
    // select and register
    ////////////////////////////////////////

    alu_result_stage u_result (
        .clk          (clk),
        .reset        (reset),
        .aluk         (aluk),
        .size         (size),
        .logic_result (logic_result),
        .arith_result (arith_result),
        .arith_cf     (arith_cf),
        .arith_af     (arith_af),
        .arith_of     (arith_of),
        .daa_result   (daa_result),
        .daa_af       (daa_af),
        .daa_cf       (daa_cf),
        .shift_result (shift_result),
        .shift_cf     (shift_cf),
        .shift_of     (shift_of),
        .bsf_zero     (bsf_zero),
        .cmp_equal    (cmp_equal),
        .swap_req     (arith_swap),
        .count_zero   (count_zero),
        .alu_out      (alu_out),
        .swap         (swap),
        .cf_out       (cf_out),
        .pf_out       (pf_out),
        .af_out       (af_out),
        .zf_out       (zf_out),
        .sf_out       (sf_out),
        .of_out       (of_out),
        .df_out       (df_out),
        .cc_inval     (cc_inval)
    );

endmodule

`default_nettype wire

/* alu_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_asserts
    import alu_pkg::*;
(
    input wire logic clk,
    input wire logic reset,
    input alu_op_t   aluk,
    input alu_word_t alu_out,
    input wire logic swap,
    input wire logic cf_out,
    input wire logic pf_out,
    input wire logic af_out,
    input wire logic zf_out,
    input wire logic sf_out,
    input wire logic of_out,
    input wire logic df_out,
    input wire logic cc_inval
);

    // everything cleared one cycle after a reset edge
    a_reset_clears: assert property (@(posedge clk)
        reset |=> (alu_out == '0) && !swap && !cf_out && !pf_out && !af_out
            && !zf_out && !sf_out && !of_out && !df_out && !cc_inval)
        else $error("outputs not cleared after reset");

    // a swap only follows an equal compare
    a_swap_zf: assert property (@(posedge clk) disable iff (reset)
        swap |-> zf_out)
        else $error("swap raised without zf_out");

    // zero-count indication only after a shift
    a_cc_shift: assert property (@(posedge clk) disable iff (reset)
        cc_inval |-> $past(aluk == op_sal || aluk == op_sar))
        else $error("cc_inval raised after a non-shift operation");

endmodule

bind alu_top alu_asserts u_asserts (
    .clk(clk), .reset(reset), .aluk(aluk), .alu_out(alu_out), .swap(swap),
    .cf_out(cf_out), .pf_out(pf_out), .af_out(af_out), .zf_out(zf_out),
    .sf_out(sf_out), .of_out(of_out), .df_out(df_out), .cc_inval(cc_inval)
);

`default_nettype wire

/* alu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "alu_settings.svh"

module alu_tb
    import alu_pkg::*;
();

    localparam int MSB           = `ALU_WIDTH - 1;
    localparam int RESET_CYCLES  = 16;
    // two cycles per operation for drive and sample
    localparam int CYCLES_PER_OP = 2;
    localparam int DAA_OPS       = 256 * 4;
    localparam int OTHER_OPS     = 300;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + CYCLES_PER_OP * (DAA_OPS + OTHER_OPS) + 50;

    logic      clk = 1'b0;
    logic      reset;
    alu_op_t   aluk;
    alu_size_t size;
    alu_word_t op1;
    alu_word_t op2;
    alu_word_t op3;
    logic      and_int;
    logic      fixed_shift;
    logic      af_in;
    logic      cf_in;
    logic      of_in;
    alu_word_t alu_out;
    logic      swap;
    logic      cf_out;
    logic      pf_out;
    logic      af_out;
    logic      zf_out;
    logic      sf_out;
    logic      of_out;
    logic      df_out;
    logic      cc_inval;

    // expected outputs of the current operation
    alu_word_t exp_out;
    logic      exp_swap;
    logic      exp_cf;
    logic      exp_pf;
    logic      exp_af;
    logic      exp_zf;
    logic      exp_sf;
    logic      exp_of;
    logic      exp_df;
    logic      exp_cc;

    // side inputs for the next operation
    logic        mode_and_int = 1'b0;
    logic        mode_fixed   = 1'b0;
    logic        flag_af      = 1'b0;
    logic        flag_cf      = 1'b0;
    logic        flag_of      = 1'b0;
    logic [31:0] lcg_state    = 32'h12b2_868c;
    int          cycle_count  = 0;

    alu_top dut0 (
        .clk(clk), .reset(reset), .aluk(aluk), .size(size),
        .op1(op1), .op2(op2), .op3(op3),
        .and_int(and_int), .fixed_shift(fixed_shift),
        .af_in(af_in), .cf_in(cf_in), .of_in(of_in),
        .alu_out(alu_out), .swap(swap),
        .cf_out(cf_out), .pf_out(pf_out), .af_out(af_out), .zf_out(zf_out),
        .sf_out(sf_out), .of_out(of_out), .df_out(df_out), .cc_inval(cc_inval)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            stop_run();
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic stop_run();
        $display(">>> FAIL");
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_word(input string test, input string field,
                              input alu_word_t exp, input alu_word_t act);
        if (act !== exp) begin
            $display("** Error: test %s, %s expected %h actual %h", test, field, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string test, input string field,
                             input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error: test %s, %s expected %b actual %b", test, field, exp, act);
            stop_run();
        end
    endtask

    task automatic compare_outputs(input string test);
        check_word(test, "alu_out", exp_out, alu_out);
        check_bit(test, "swap", exp_swap, swap);
        check_bit(test, "cf_out", exp_cf, cf_out);
        check_bit(test, "pf_out", exp_pf, pf_out);
        check_bit(test, "af_out", exp_af, af_out);
        check_bit(test, "zf_out", exp_zf, zf_out);
        check_bit(test, "sf_out", exp_sf, sf_out);
        check_bit(test, "of_out", exp_of, of_out);
        check_bit(test, "df_out", exp_df, df_out);
        check_bit(test, "cc_inval", exp_cc, cc_inval);
    endtask

    // value of bits top:0 read as two's complement
    function automatic longint signed_field(input alu_word_t w, input int top);
        longint v;
        v = 0;
        for (int i = 0; i < top; i++) begin
            if (w[i]) v += longint'(1) << i;
        end
        if (w[top]) v -= longint'(1) << top;
        return v;
    endfunction

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    task automatic predict(input logic [`ALU_OP_BITS-1:0] code, input alu_size_t sz,
                           input alu_word_t a, input alu_word_t b, input alu_word_t c);
        alu_word_t  r;
        alu_word_t  mask;
        logic       cf;
        logic       af;
        logic       of;
        logic       known;
        logic       fixed_zf;
        logic       zf_val;
        logic       found;
        logic       over;
        logic [7:0] al;
        int         top;
        int         cnt;
        longint     wide;
        longint     lim;
        r = '0;
        cf = 1'b0;
        af = 1'b0;
        of = 1'b0;
        known = 1'b1;
        fixed_zf = 1'b0;
        zf_val = 1'b0;
        exp_swap = 1'b0;
        exp_df = 1'b0;
        exp_cc = 1'b0;
        top = (sz == size_byte) ? 7 : (sz == size_word) ? 15 : MSB;
        case (code)
            op_and:   r = a & (mode_and_int ? alu_word_t'(`ALU_AND_INT_MASK) : b);
            op_or:    r = a | b;
            op_not:   r = ~a;
            op_mova:  r = a;
            op_movb:  r = b;
            op_cmovc: r = flag_cf ? b : a;
            op_cld:   r = '0;
            op_std: begin
                r = alu_word_t'(1);
                exp_df = 1'b1;
            end
            op_add: begin
                wide = longint'(a) + longint'(b);
                r = wide[MSB:0];
                cf = wide[MSB+1];
                af = (int'(a[3:0]) + int'(b[3:0])) > 15;
                lim = longint'(1) << top;
                wide = signed_field(a, top) + signed_field(b, top);
                of = (wide >= lim) || (wide < -lim);
            end
            op_cmpxchg: begin
                cf = a < b;
                af = a[3:0] < b[3:0];
                lim = longint'(1) << MSB;
                wide = signed_field(a, MSB) - signed_field(b, MSB);
                of = (wide >= lim) || (wide < -lim);
                r = (a == c) ? b : a;
                fixed_zf = 1'b1;
                zf_val = (a == c);
                exp_swap = (a == c);
            end
            op_bsf: begin
                found = 1'b0;
                for (int i = 0; i <= MSB; i++) begin
                    if (a[i] && !found) begin
                        r = alu_word_t'(i);
                        found = 1'b1;
                    end
                end
                fixed_zf = 1'b1;
                zf_val = (a == '0);
            end
            op_daa: begin
                al = a[7:0];
                if (a[3:0] > 4'd9 || flag_af) begin
                    al = al + 8'h06;
                    af = 1'b1;
                end
                if (a[7:0] > 8'h99 || flag_cf) begin
                    al = al + 8'h60;
                    cf = 1'b1;
                end
                r = alu_word_t'(al);
            end
            op_sal, op_sar: begin
                cnt = mode_fixed ? `ALU_FIXED_SHIFT : int'(b[4:0]);
                over = (b[7:5] != 3'd0) && !mode_fixed;
                if (over) begin
                    r = (code == op_sal) ? '0 : {`ALU_WIDTH{a[MSB]}};
                    cf = (code == op_sal) ? 1'b0 : a[MSB];
                end else if (code == op_sal) begin
                    r = a << cnt;
                    cf = (cnt == 0) ? 1'b0 : a[`ALU_WIDTH - cnt];
                end else begin
                    r = $signed(a) >>> cnt;
                    cf = (cnt == 0) ? 1'b0 : a[cnt - 1];
                end
                if (cnt == 1) of = (code == op_sal) ? (r[MSB] ^ cf) : 1'b0;
                else of = flag_of;
                exp_cc = (cnt == 0) && !over;
            end
            default: known = 1'b0;
        endcase
        mask = alu_word_t'((longint'(1) << (top + 1)) - 1);
        exp_out = r;
        exp_cf = cf;
        exp_af = af;
        exp_of = of;
        exp_sf = known && r[top];
        exp_pf = known && ~^r[7:0];
        exp_zf = known && (fixed_zf ? zf_val : ((r & mask) == '0));
    endtask

    // drive on a rising edge and sample after the next one
    task automatic apply_op(input string test, input logic [`ALU_OP_BITS-1:0] code,
                            input alu_size_t sz, input alu_word_t a, input alu_word_t b,
                            input alu_word_t c);
        @(posedge clk);
        aluk        <= alu_op_t'(code);
        size        <= sz;
        op1         <= a;
        op2         <= b;
        op3         <= c;
        and_int     <= mode_and_int;
        fixed_shift <= mode_fixed;
        af_in       <= flag_af;
        cf_in       <= flag_cf;
        of_in       <= flag_of;
        predict(code, sz, a, b, c);
        @(posedge clk);
        @(negedge clk);
        compare_outputs(test);
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        predict(5'd31, size_dword, '0, '0, '0);
        compare_outputs("reset");
    endtask

    task automatic test_logic();
        alu_word_t a;
        alu_word_t b;
        alu_size_t sz;
        for (int i = 0; i < 12; i++) begin
            a = next_random();
            b = next_random();
            sz = alu_size_t'(i % 3);
            apply_op("and", op_and, sz, a, b, '0);
            mode_and_int = 1'b1;
            apply_op("and masked", op_and, sz, a, b, '0);
            mode_and_int = 1'b0;
            apply_op("or", op_or, sz, a, b, '0);
            apply_op("not", op_not, sz, a, b, '0);
            apply_op("mova", op_mova, sz, a, b, '0);
            apply_op("movb", op_movb, sz, a, b, '0);
            flag_cf = 1'b1;
            apply_op("cmovc taken", op_cmovc, sz, a, b, '0);
            flag_cf = 1'b0;
            apply_op("cmovc kept", op_cmovc, sz, a, b, '0);
        end
        apply_op("mova zero", op_mova, size_dword, '0, 32'h1234_5678, '0);
    endtask

    task automatic test_add();
        apply_op("add byte overflow", op_add, size_byte, 32'h7F, 32'h1, '0);
        apply_op("add word overflow", op_add, size_word, 32'h7FFF, 32'h1, '0);
        apply_op("add dword overflow", op_add, size_dword, 32'h7FFF_FFFF, 32'h1, '0);
        apply_op("add carry out", op_add, size_dword, 32'hFFFF_FFFF, 32'h1, '0);
        apply_op("add half carry", op_add, size_byte, 32'h0F, 32'h1, '0);
        apply_op("add byte wrap", op_add, size_byte, 32'hFF, 32'h1, '0);
        for (int i = 0; i < 24; i++) begin
            apply_op("add random", op_add, alu_size_t'(i % 3), next_random(), next_random(), '0);
        end
    endtask

    task automatic test_shift();
        alu_word_t a;
        alu_word_t b;
        for (int i = 0; i < 10; i++) begin
            a = next_random();
            b = next_random() & 32'hFFFF_FF1F;
            flag_of = ^next_random();
            apply_op("sal random", op_sal, size_dword, a, b, '0);
            apply_op("sar random", op_sar, size_dword, a, b, '0);
        end
        flag_of = 1'b1;
        for (int i = 0; i < 3; i++) begin
            b = (i == 0) ? 32'h4000_0000 : (i == 1) ? 32'hC000_0001 : next_random();
            apply_op("sal count 1", op_sal, size_dword, b, 32'h1, '0);
            apply_op("sar count 1", op_sar, size_dword, b, 32'h1, '0);
        end
        mode_fixed = 1'b1;
        for (int i = 0; i < 3; i++) begin
            a = next_random();
            b = next_random();
            apply_op("sal fixed", op_sal, size_word, a, b, '0);
            apply_op("sar fixed", op_sar, size_word, a, b, '0);
        end
        mode_fixed = 1'b0;
        apply_op("sal overshift", op_sal, size_dword, 32'h8000_0001, 32'h20, '0);
        apply_op("sar overshift", op_sar, size_dword, 32'h8000_0001, 32'hE3, '0);
        apply_op("sal overshift pos", op_sal, size_dword, 32'h1234_5678, 32'h41, '0);
        apply_op("sar overshift pos", op_sar, size_dword, 32'h1234_5678, 32'h41, '0);
        apply_op("sal count 0", op_sal, size_dword, 32'h8000_0003, 32'h0, '0);
        apply_op("sar count 0", op_sar, size_dword, 32'h8000_0003, 32'h100, '0);
        apply_op("sal count 0 over", op_sal, size_dword, 32'h8000_0003, 32'h20, '0);
        apply_op("sar count 0 over", op_sar, size_dword, 32'h8000_0003, 32'h60, '0);
        flag_of = 1'b0;
    endtask

    task automatic test_cmpxchg_bsf();
        alu_word_t a;
        for (int i = 0; i < 8; i++) begin
            a = next_random();
            apply_op("cmpxchg equal", op_cmpxchg, size_dword, a, next_random(), a);
            apply_op("cmpxchg unequal", op_cmpxchg, size_dword, a, next_random(), a ^ 32'h1);
        end
        apply_op("cmpxchg borrow", op_cmpxchg, size_dword, 32'h0, 32'h1, 32'h5);
        apply_op("cmpxchg overflow", op_cmpxchg, size_dword, 32'h8000_0000, 32'h1, 32'h0);
        apply_op("cmpxchg same", op_cmpxchg, size_dword, 32'h42, 32'h42, 32'h42);
        apply_op("bsf zero", op_bsf, size_dword, '0, '0, '0);
        for (int i = 0; i < `ALU_WIDTH; i++) begin
            apply_op("bsf one-hot", op_bsf, size_dword, alu_word_t'(1) << i, '0, '0);
        end
        for (int i = 0; i < 8; i++) begin
            apply_op("bsf random", op_bsf, size_dword, next_random(), '0, '0);
        end
    endtask

    task automatic test_daa_misc();
        for (int al = 0; al < 256; al++) begin
            for (int fl = 0; fl < 4; fl++) begin
                flag_af = fl[0];
                flag_cf = fl[1];
                apply_op("daa", op_daa, size_byte, (next_random() & 32'hFFFF_FF00) | al, '0, '0);
            end
        end
        flag_af = 1'b0;
        flag_cf = 1'b0;
        apply_op("cld", op_cld, size_dword, next_random(), next_random(), '0);
        apply_op("std", op_std, size_dword, next_random(), next_random(), '0);
        for (int code = 11; code < 32; code++) begin
            if (code < 17 || code > 19) begin
                apply_op("unused code", 5'(code), size_dword, next_random(), next_random(), '0);
            end
        end
    endtask

    initial begin
        reset       = 1'b1;
        aluk        = op_and;
        size        = size_dword;
        op1         = '0;
        op2         = '0;
        op3         = '0;
        and_int     = 1'b0;
        fixed_shift = 1'b0;
        af_in       = 1'b0;
        cf_in       = 1'b0;
        of_in       = 1'b0;
        test_reset();
        test_logic();
        test_add();
        test_shift();
        test_cmpxchg_bsf();
        test_daa_misc();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
alu_pkg.sv
alu_logic_unit.sv
alu_arith.sv
alu_bcd_adjust.sv
alu_shifter.sv
alu_result_stage.sv
alu_top.sv
alu_asserts.sv
alu_tb.sv
